// File: tb/golden_programs.hex
// All values hex. Test count, then per test: word count N, N instruction words,
// expected v0, expected data word at 0x100, step bound (committed instructions)
00000003
// Arithmetic, logic and shifts
00000018
24081234 2409FFFD 01095021 01095823 3C0CF0F0 358C00FF 000C6903 000C7202
00087900 01AE8026 020F8824 0128902A 0128982B 2934FFFE 3135FF00 3AB60F0F
014B1021 00511026 00561021 004E1023 00521021 00531021 00541021 00000008
FF110479 00000000 0000001E
// SW then LW through a pointer
00000009
24080100 3C09CAFE 3529BABE AD090000 AD080004 8D0A0004 8D420000 24420001
00000008
CAFEBABF CAFEBABE 0000000F
// Loop with BNE, BEQ untaken and taken, JAL, JR $31, J
00000011
24020000 24080003 24420001 2508FFFF 1500FFFD 10400001 24420010 10000001
24420100 0FF0000D 24420200 0BF0000F 24420400 24420020 03E00008 AC020100
00000008
00000233 00000233 0000001E

// File: vlog.f
src/mipsPkg.sv
src/controlUnit.sv
src/aluUnit.sv
src/nextPcUnit.sv
src/registerFile.sv
src/mipsCpuHarvard.sv
tb/mipsCpuTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mipsCpuTb -f vlog.f

# Simulation passes only if the pass message is printed
./obj_dir/VmipsCpuTb | tee /dev/stderr | grep "PASS: all tests" > /dev/null
echo "Simulation passed"

// File: tb/mipsCpuTb.sv
module mipsCpuTb import mipsPkg::*; ();

  logic        clk;
  logic        reset;
  logic        clk_enable;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic        data_write;
  logic        data_read;
  logic [31:0] data_writedata;
  logic [31:0] data_readdata;

  logic [31:0] instrMem [256];
  logic [31:0] dataMem [256];
  logic [31:0] golden [1024];
  logic [31:0] instrOffset;
  logic [9:0]  ptr;
  logic        clearMem;
  logic [31:0] lfsrState;
  int          watchdogCycles;

  mipsCpuHarvard i_dut (
    .clk(clk), .reset(reset), .clk_enable(clk_enable), .active(active),
    .register_v0(register_v0), .instr_address(instr_address),
    .instr_readdata(instr_readdata), .data_address(data_address),
    .data_write(data_write), .data_read(data_read),
    .data_writedata(data_writedata), .data_readdata(data_readdata)
  );

  always #4 clk = ~clk;

  // Program image starts at the reset vector
  assign instrOffset    = instr_address - resetVector;
  assign instr_readdata = instrMem[instrOffset[9:2]];
  assign data_readdata  = dataMem[data_address[9:2]];

  always @(posedge clk)
  begin
    if (clearMem)
    begin
      for (int k = 0; k < 256; k++)
        dataMem[k[7:0]] <= 32'd0;
    end
    else if (data_write)
      dataMem[data_address[9:2]] <= data_writedata;
  end

  // Galois LFSR, one step per bit
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Enable is low only when both bits are set
  task automatic driveEnable();
    logic a;
    logic b;
    lfsrState = lfsrNext(lfsrState);
    a = lfsrState[0];
    lfsrState = lfsrNext(lfsrState);
    b = lfsrState[0];
    clk_enable = !(a && b);
  endtask

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, what, actual,
               expected);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic nextGolden(output logic [31:0] value);
    value = golden[ptr];
    ptr = ptr + 10'd1;
  endtask

  task automatic resetCore();
    reset      = 1'b1;
    clearMem   = 1'b1;
    clk_enable = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    reset    = 1'b0;
    clearMem = 1'b0;
    @(negedge clk);
    checkValue(32'(active), 32'd1, "active after reset");
    checkValue(instr_address, resetVector, "PC after reset");
    checkValue(register_v0, 32'd0, "v0 after reset");
    checkValue(32'(data_write), 32'd0, "data_write after reset");
    @(posedge clk);
    #1;
  endtask

  task automatic runTest(input int testNo);
    logic [31:0] count;
    logic [31:0] word;
    logic [31:0] expV0;
    logic [31:0] expMem;
    logic [31:0] bound;
    logic [31:0] steps;
    logic [31:0] prevPc;
    logic [31:0] prevV0;
    logic        wasEnabled;
    $display("Running test %0d", testNo);
    nextGolden(count);
    for (int k = 0; k < 256; k++)
      instrMem[k[7:0]] = 32'd0;
    for (int k = 0; k < int'(count); k++)
    begin
      nextGolden(word);
      instrMem[k[7:0]] = word;
    end
    nextGolden(expV0);
    nextGolden(expMem);
    nextGolden(bound);
    resetCore();
    steps = 32'd0;
    while (active)
    begin
      driveEnable();
      prevPc = instr_address;
      prevV0 = register_v0;
      @(negedge clk);
      wasEnabled = clk_enable;
      // Only a load reads data memory
      checkValue(32'(data_read), 32'(instr_readdata[31:26] == opLw),
                 "data_read for fetched instruction");
      if (!wasEnabled)
        checkValue(32'(data_write), 32'd0, "data_write with clock enable low");
      @(posedge clk);
      #1;
      if (wasEnabled)
        steps = steps + 32'd1;
      else
      begin
        checkValue(instr_address, prevPc, "PC hold with clock enable low");
        checkValue(register_v0, prevV0, "v0 hold with clock enable low");
      end
    end
    checkValue(32'(steps <= bound), 32'd1, "halt within step bound");
    // Core must stay frozen at address zero
    repeat (20)
    begin
      driveEnable();
      @(negedge clk);
      checkValue(32'(active), 32'd0, "active after halt");
      checkValue(instr_address, 32'd0, "PC after halt");
      checkValue(32'(data_write), 32'd0, "data_write after halt");
      @(posedge clk);
      #1;
    end
    checkValue(register_v0, expV0, "final v0");
    checkValue(dataMem[8'h40], expMem, "data word at 0x100");
  endtask

  initial
  begin
    logic [31:0] numTests;
    logic [31:0] boundSum;
    logic [9:0]  scan;
    clk            = 1'b0;
    reset          = 1'b1;
    clk_enable     = 1'b0;
    clearMem       = 1'b1;
    lfsrState      = 32'h6c16_6682;
    watchdogCycles = 0;
    $readmemh("tb/golden_programs.hex", golden);
    numTests = golden[0];
    // Step bound of each test sits after its words, v0 and memory word
    scan     = 10'd1;
    boundSum = 32'd0;
    for (int t = 0; t < int'(numTests); t++)
    begin
      scan     = scan + golden[scan][9:0] + 10'd3;
      boundSum = boundSum + golden[scan];
      scan     = scan + 10'd1;
    end
    // Reset, hold checks and halt window take under 48 cycles per test
    watchdogCycles = int'(boundSum) * 4 + int'(numTests) * 48;
    ptr = 10'd1;
    for (int t = 0; t < int'(numTests); t++)
      runTest(t + 1);
    $display("PASS: all tests");
    $finish;
  end

  initial
  begin
    wait (watchdogCycles > 0);
    repeat (watchdogCycles) @(posedge clk);
    $display("timeout: program did not halt");
    $display("FAIL: see errors above");
    $fatal(1);
  end

endmodule

// File: src/mipsCpuHarvard.sv
module mipsCpuHarvard import mipsPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  output logic        active,
  output logic [31:0] register_v0,
  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,
  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);

  instrWord_u            instr;
  logic                  regWrite;
  logic                  regDst;
  logic                  memToReg;
  logic                  memRead;
  logic                  memWrite;
  logic                  link;
  logic                  aluSrcImm;
  logic                  zeroExtend;
  logic                  branch;
  logic                  branchNe;
  logic                  jump;
  logic                  jumpReg;
  logic [aluOpWidth-1:0] aluOp;
  logic [31:0]           rsData;
  logic [31:0]           rtData;
  logic [31:0]           aluResult;
  logic                  equal;
  logic [31:0]           pcPlus4;

  assign instr = instr_readdata;

  controlUnit u_control (
    .instr(instr), .regWrite(regWrite), .regDst(regDst), .memToReg(memToReg),
    .memRead(memRead), .memWrite(memWrite), .link(link), .aluSrcImm(aluSrcImm),
    .zeroExtend(zeroExtend), .branch(branch), .branchNe(branchNe), .jump(jump),
    .jumpReg(jumpReg), .aluOp(aluOp)
  );

  registerFile u_regs (
    .clk(clk), .reset(reset), .clk_enable(clk_enable), .active(active),
    .instr(instr), .regWrite(regWrite), .regDst(regDst), .memToReg(memToReg),
    .link(link), .aluResult(aluResult), .memData(data_readdata), .pcPlus4(pcPlus4),
    .rsData(rsData), .rtData(rtData), .register_v0(register_v0)
  );

  aluUnit u_alu (
    .instr(instr), .rsData(rsData), .rtData(rtData), .aluOp(aluOp),
    .aluSrcImm(aluSrcImm), .zeroExtend(zeroExtend), .aluResult(aluResult),
    .equal(equal)
  );

  nextPcUnit u_nextPc (
    .clk(clk), .reset(reset), .clk_enable(clk_enable), .instr(instr),
    .rsData(rsData), .equal(equal), .branch(branch), .branchNe(branchNe),
    .jump(jump), .jumpReg(jumpReg), .pc(instr_address), .pcPlus4(pcPlus4),
    .active(active)
  );

  // Memory side
  assign data_address   = aluResult;
  assign data_writedata = rtData;
  assign data_read      = memRead;
  // Store strobe only in a cycle that commits
  assign data_write     = memWrite && clk_enable && active;

endmodule

// File: src/registerFile.sv
module registerFile import mipsPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  input  logic        active,
  input  instrWord_u  instr,
  input  logic        regWrite,
  input  logic        regDst,
  input  logic        memToReg,
  input  logic        link,
  input  logic [31:0] aluResult,
  input  logic [31:0] memData,
  input  logic [31:0] pcPlus4,
  output logic [31:0] rsData,
  output logic [31:0] rtData,
  output logic [31:0] register_v0
);

  logic [31:0] regs [32];
  logic [4:0]  writeReg;
  logic [31:0] writeData;

  // Destination is rd, rt, or ra for JAL
  assign writeReg  = link ? regRa : (regDst ? instr.r.rd : instr.r.rt);
  assign writeData = link ? pcPlus4 : (memToReg ? memData : aluResult);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int k = 0; k < 32; k++)
        regs[k] <= 32'd0;
    end
    else if (clk_enable && active && regWrite && (writeReg != 5'd0))
    begin
      regs[writeReg] <= writeData;
    end
  end

  assign rsData      = regs[instr.r.rs];
  assign rtData      = regs[instr.r.rt];
  assign register_v0 = regs[regV0];

  // $zero reads as zero across every write-back
  zeroReg: assert property (@(posedge clk) disable iff (reset)
    (instr.r.rs == 5'd0) |-> (rsData == 32'd0));

endmodule

// File: src/nextPcUnit.sv
module nextPcUnit import mipsPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  input  instrWord_u  instr,
  input  logic [31:0] rsData,
  input  logic        equal,
  input  logic        branch,
  input  logic        branchNe,
  input  logic        jump,
  input  logic        jumpReg,
  output logic [31:0] pc,
  output logic [31:0] pcPlus4,
  output logic        active
);

  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;
  logic [31:0] nextPc;
  logic        takeBranch;

  assign pcPlus4      = pc + 32'd4;
  assign branchTarget = pcPlus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
  assign jumpTarget   = {pcPlus4[31:28], instr.j.target, 2'b00};
  assign takeBranch   = branch && (branchNe ? !equal : equal);

  always_comb
  begin
    if (jumpReg)
      nextPc = rsData;
    else if (jump)
      nextPc = jumpTarget;
    else if (takeBranch)
      nextPc = branchTarget;
    else
      nextPc = pcPlus4;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc     <= resetVector;
      active <= 1'b1;
    end
    else if (clk_enable && active)
    begin
      pc <= nextPc;
      // Halt once control reaches address zero
      if (nextPc == 32'd0)
        active <= 1'b0;
    end
  end

  // Fetch address stays word aligned while running
  pcAligned: assert property (@(posedge clk) disable iff (reset)
    active |-> (pc[1:0] == 2'b00));

endmodule

// File: src/aluUnit.sv
module aluUnit import mipsPkg::*; (
  input  instrWord_u              instr,
  input  logic [31:0]             rsData,
  input  logic [31:0]             rtData,
  input  logic [aluOpWidth-1:0]   aluOp,
  input  logic                    aluSrcImm,
  input  logic                    zeroExtend,
  output logic [31:0]             aluResult,
  output logic                    equal
);

  logic [31:0] immExt;
  logic [31:0] opB;
  logic [4:0]  shamt;

  // Sign or zero extension of the 16-bit immediate
  assign immExt = zeroExtend ? {16'h0000, instr.i.imm}
                             : {{16{instr.i.imm[15]}}, instr.i.imm};

  assign opB   = aluSrcImm ? immExt : rtData;
  assign shamt = instr.r.shamt;

  always_comb
  begin
    case (aluOp)
      aluAdd:  aluResult = rsData + opB;
      aluSub:  aluResult = rsData - opB;
      aluAnd:  aluResult = rsData & opB;
      aluOr:   aluResult = rsData | opB;
      aluXor:  aluResult = rsData ^ opB;
      aluSlt:  aluResult = {31'd0, $signed(rsData) < $signed(opB)};
      aluSltu: aluResult = {31'd0, rsData < opB};
      // Shifts act on rt by the shamt field
      aluSll:  aluResult = rtData << shamt;
      aluSrl:  aluResult = rtData >> shamt;
      aluSra:  aluResult = $unsigned($signed(rtData) >>> shamt);
      aluLui:  aluResult = {instr.i.imm, 16'h0000};
      default: aluResult = 32'd0;
    endcase
  end

  // Branch compare, independent of the operand mux
  assign equal = (rsData == rtData);

endmodule

// File: src/controlUnit.sv
module controlUnit import mipsPkg::*; (
  input  instrWord_u              instr,
  output logic                    regWrite,
  output logic                    regDst,
  output logic                    memToReg,
  output logic                    memRead,
  output logic                    memWrite,
  output logic                    link,
  output logic                    aluSrcImm,
  output logic                    zeroExtend,
  output logic                    branch,
  output logic                    branchNe,
  output logic                    jump,
  output logic                    jumpReg,
  output logic [aluOpWidth-1:0]   aluOp
);

  always_comb
  begin
    // Safe defaults, nothing written and no memory access
    regWrite   = 1'b0;
    regDst     = 1'b0;
    memToReg   = 1'b0;
    memRead    = 1'b0;
    memWrite   = 1'b0;
    link       = 1'b0;
    aluSrcImm  = 1'b0;
    zeroExtend = 1'b0;
    branch     = 1'b0;
    branchNe   = 1'b0;
    jump       = 1'b0;
    jumpReg    = 1'b0;
    aluOp      = aluAdd;

    case (instr.r.opcode)
      opSpecial:
      begin
        regDst   = 1'b1;
        regWrite = 1'b1;
        case (instr.r.funct)
          fnAddu: aluOp = aluAdd;
          fnSubu: aluOp = aluSub;
          fnAnd:  aluOp = aluAnd;
          fnOr:   aluOp = aluOr;
          fnXor:  aluOp = aluXor;
          fnSlt:  aluOp = aluSlt;
          fnSltu: aluOp = aluSltu;
          fnSll:  aluOp = aluSll;
          fnSrl:  aluOp = aluSrl;
          fnSra:  aluOp = aluSra;
          fnJr:
          begin
            regWrite = 1'b0;
            jumpReg  = 1'b1;
          end
          default: regWrite = 1'b0;
        endcase
      end
      opJ: jump = 1'b1;
      opJal:
      begin
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      opBeq: branch = 1'b1;
      opBne:
      begin
        branch   = 1'b1;
        branchNe = 1'b1;
      end
      opAddiu, opSlti, opAndi, opOri, opXori, opLui:
      begin
        regWrite  = 1'b1;
        aluSrcImm = 1'b1;
        case (instr.i.opcode)
          opSlti:  aluOp = aluSlt;
          opAndi:  aluOp = aluAnd;
          opOri:   aluOp = aluOr;
          opXori:  aluOp = aluXor;
          opLui:   aluOp = aluLui;
          default: aluOp = aluAdd;
        endcase
        // Logical immediates are zero-extended
        zeroExtend = (instr.i.opcode == opAndi) || (instr.i.opcode == opOri) ||
                     (instr.i.opcode == opXori);
      end
      opLw:
      begin
        regWrite  = 1'b1;
        memRead   = 1'b1;
        memToReg  = 1'b1;
        aluSrcImm = 1'b1;
      end
      opSw:
      begin
        memWrite  = 1'b1;
        aluSrcImm = 1'b1;
      end
      default: ;
    endcase
  end

  // Decode never requests a load and a store for the same word
  noLoadAndStore: assert property (@(instr) !(memRead && memWrite));

endmodule

// File: src/mipsPkg.sv
package mipsPkg;

  // Primary opcodes
  localparam logic [5:0] opSpecial = 6'h00;
  localparam logic [5:0] opJ       = 6'h02;
  localparam logic [5:0] opJal     = 6'h03;
  localparam logic [5:0] opBeq     = 6'h04;
  localparam logic [5:0] opBne     = 6'h05;
  localparam logic [5:0] opAddiu   = 6'h09;
  localparam logic [5:0] opSlti    = 6'h0A;
  localparam logic [5:0] opAndi    = 6'h0C;
  localparam logic [5:0] opOri     = 6'h0D;
  localparam logic [5:0] opXori    = 6'h0E;
  localparam logic [5:0] opLui     = 6'h0F;
  localparam logic [5:0] opLw      = 6'h23;
  localparam logic [5:0] opSw      = 6'h2B;

  // Funct field of SPECIAL
  localparam logic [5:0] fnSll  = 6'h00;
  localparam logic [5:0] fnSrl  = 6'h02;
  localparam logic [5:0] fnSra  = 6'h03;
  localparam logic [5:0] fnJr   = 6'h08;
  localparam logic [5:0] fnAddu = 6'h21;
  localparam logic [5:0] fnSubu = 6'h23;
  localparam logic [5:0] fnAnd  = 6'h24;
  localparam logic [5:0] fnOr   = 6'h25;
  localparam logic [5:0] fnXor  = 6'h26;
  localparam logic [5:0] fnSlt  = 6'h2A;
  localparam logic [5:0] fnSltu = 6'h2B;

  // Internal ALU operations
  localparam int aluOpWidth = 4;
  localparam logic [aluOpWidth-1:0] aluAdd  = 4'd0;
  localparam logic [aluOpWidth-1:0] aluSub  = 4'd1;
  localparam logic [aluOpWidth-1:0] aluAnd  = 4'd2;
  localparam logic [aluOpWidth-1:0] aluOr   = 4'd3;
  localparam logic [aluOpWidth-1:0] aluXor  = 4'd4;
  localparam logic [aluOpWidth-1:0] aluSlt  = 4'd5;
  localparam logic [aluOpWidth-1:0] aluSltu = 4'd6;
  localparam logic [aluOpWidth-1:0] aluSll  = 4'd7;
  localparam logic [aluOpWidth-1:0] aluSrl  = 4'd8;
  localparam logic [aluOpWidth-1:0] aluSra  = 4'd9;
  localparam logic [aluOpWidth-1:0] aluLui  = 4'd10;

  localparam logic [31:0] resetVector = 32'hBFC00000;
  localparam logic [4:0]  regV0       = 5'd2;
  // JAL link register
  localparam logic [4:0]  regRa       = 5'd31;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rView_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iView_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } jView_t;

  // One instruction word, three field layouts
  typedef union packed {
    rView_t r;
    iView_t i;
    jView_t j;
  } instrWord_u;

endpackage
